// File: Bender.yml
package:
  name: noc_tile

sources:
  - noc_tile_pkg.sv
  - tile_reset_ctrl.sv
  - irq_notifier.sv
  - req_packetizer.sv
  - noc_tx_mux.sv
  - noc_tile_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_noc_tile.sv

// File: irq_notifier.sv
`timescale 1ns/1ps

module irq_notifier #(
  parameter noc_tile_pkg::tile_id_t   DestTile  = '0,
  parameter noc_tile_pkg::noc_fbits_t DestFbits = '0
) (
  input  logic                       clk_i,
  input  logic                       tile_rst_l_i,
  input  noc_tile_pkg::tile_id_t     tile_id_i,
  input  noc_tile_pkg::irq_lines_t   irq_lines_i,
  output noc_tile_pkg::flit_stream_t irq_o,
  input  logic                       irq_ready_i
);

  import noc_tile_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_PAYLOAD
  } state_e;

  state_e     state_q;
  state_e     state_d;
  irq_lines_t sync1_q;
  irq_lines_t sync2_q;
  irq_lines_t reported_q;
  irq_lines_t reported_d;
  logic       pending;
  logic       capture;

  ////////////////////
  // line sync
  ////////////////////

  // async levels, two flops each
  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= irq_lines_i;
      sync2_q <= sync1_q;
    end
  end

  ////////////////////
  // change detect
  ////////////////////

  assign pending = (state_q != ST_IDLE);
  // no queueing, a change seen mid-packet is picked up afterwards
  assign capture = !pending && (sync2_q != reported_q);

  always_comb begin
    state_d    = state_q;
    reported_d = reported_q;
    case (state_q)
      ST_IDLE: begin
        if (capture) begin
          reported_d = sync2_q;
          state_d    = ST_HDR;
        end
      end
      ST_HDR: begin
        if (irq_ready_i) begin
          state_d = ST_PAYLOAD;
        end
      end
      ST_PAYLOAD: begin
        // back to idle, compare again next cycle
        if (irq_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      state_q    <= ST_IDLE;
      reported_q <= '0;
    end else begin
      state_q    <= state_d;
      reported_q <= reported_d;
    end
  end

  ////////////////////
  // flit out
  ////////////////////

  // header then one payload flit with the value in the low bits
  always_comb begin
    irq_o       = '0;
    irq_o.valid = pending;
    irq_o.last  = (state_q == ST_PAYLOAD);
    if (state_q == ST_PAYLOAD) begin
      irq_o.flit = noc_flit_t'(reported_q);
    end else begin
      irq_o.flit = noc_make_hdr(DestTile, DestFbits, 8'd1, MSG_INTR, tile_id_i);
    end
  end

endmodule

// File: noc_tile_pkg.sv
package noc_tile_pkg;

  ////////////////////
  // widths
  ////////////////////

  // one flit on the outgoing channel
  localparam int unsigned NocDataWidth  = 64;
  localparam int unsigned NocFbitsWidth = 4;
  localparam int unsigned NocLenWidth   = 8;
  localparam int unsigned NocMsgWidth   = 8;
  // header bits above the destination, always zero
  localparam int unsigned NocRsvdWidth  = 10;
  // only the low x nibble names the sender
  localparam int unsigned NocSrcXWidth  = 4;

  // tile coordinates
  localparam int unsigned ChipIdWidth = 14;
  localparam int unsigned XPosWidth   = 8;
  localparam int unsigned YPosWidth   = 8;

  // memory request payload
  localparam int unsigned MemAddrWidth = 64;
  localparam int unsigned MemDataWidth = 64;

  ////////////////////
  // types
  ////////////////////

  typedef logic [NocDataWidth-1:0]  noc_flit_t;
  typedef logic [NocFbitsWidth-1:0] noc_fbits_t;

  // message types carried in the header
  typedef enum logic [NocMsgWidth-1:0] {
    MSG_LOAD  = 8'd19,
    MSG_STORE = 8'd20,
    MSG_INTR  = 8'd32
  } noc_msg_e;

  typedef struct packed {
    logic [ChipIdWidth-1:0] chipid;
    logic [XPosWidth-1:0]   x;
    logic [YPosWidth-1:0]   y;
  } tile_id_t;

  // header flit, msb first
  typedef struct packed {
    logic [NocRsvdWidth-1:0] rsvd;
    tile_id_t                dest;
    noc_fbits_t              dest_fbits;
    // flits after the header
    logic [NocLenWidth-1:0]  len;
    noc_msg_e                msg;
    logic [NocSrcXWidth-1:0] src_x;
  } noc_hdr_t;

  typedef struct packed {
    logic                    write;
    logic [MemAddrWidth-1:0] addr;
    logic [MemDataWidth-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [1:0] irq;
    logic       ipi;
    logic       time_irq;
    logic       debug_req;
  } irq_lines_t;

  // producer to mux link, ready runs beside it
  typedef struct packed {
    logic      valid;
    logic      last;
    noc_flit_t flit;
  } flit_stream_t;

  // build a header flit, shared by both producers
  function automatic noc_flit_t noc_make_hdr(
    input tile_id_t               dest,
    input noc_fbits_t             fbits,
    input logic [NocLenWidth-1:0] len,
    input noc_msg_e               msg,
    input tile_id_t               src
  );
    noc_hdr_t hdr;
    hdr            = '0;
    hdr.dest       = dest;
    hdr.dest_fbits = fbits;
    hdr.len        = len;
    hdr.msg        = msg;
    hdr.src_x      = src.x[NocSrcXWidth-1:0];
    return noc_flit_t'(hdr);
  endfunction

endpackage

// File: noc_tile_top.sv
`timescale 1ns/1ps

module noc_tile_top #(
  parameter int unsigned              WakeCntWidth = 16,
  parameter noc_tile_pkg::tile_id_t   DestTile     = '0,
  parameter noc_tile_pkg::noc_fbits_t DestFbits    = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_l,
  input  noc_tile_pkg::tile_id_t   tile_id_i,
  input  logic                     req_valid_i,
  input  noc_tile_pkg::mem_req_t   req_i,
  output logic                     req_ready_o,
  input  noc_tile_pkg::irq_lines_t irq_lines_i,
  output logic                     noc_valid_o,
  output noc_tile_pkg::noc_flit_t  noc_data_o,
  input  logic                     noc_ready_i,
  output logic                     tile_rst_l_o
);

  import noc_tile_pkg::*;

  // producer streams into the mux
  flit_stream_t irq_stream;
  flit_stream_t pkt_stream;
  logic         irq_ready;
  logic         pkt_ready;

  ////////////////////
  // reset
  ////////////////////

  // exported reset also clears the rest of the tile
  tile_reset_ctrl #(
    .WakeCntWidth ( WakeCntWidth )
  ) u_reset_ctrl (
    .clk_i        ( clk_i        ),
    .reset_l      ( reset_l      ),
    .tile_rst_l_o ( tile_rst_l_o )
  );

  ////////////////////
  // producers
  ////////////////////

  irq_notifier #(
    .DestTile  ( DestTile  ),
    .DestFbits ( DestFbits )
  ) u_irq_notifier (
    .clk_i        ( clk_i        ),
    .tile_rst_l_i ( tile_rst_l_o ),
    .tile_id_i    ( tile_id_i    ),
    .irq_lines_i  ( irq_lines_i  ),
    .irq_o        ( irq_stream   ),
    .irq_ready_i  ( irq_ready    )
  );

  req_packetizer #(
    .DestTile  ( DestTile  ),
    .DestFbits ( DestFbits )
  ) u_req_packetizer (
    .clk_i        ( clk_i        ),
    .tile_rst_l_i ( tile_rst_l_o ),
    .tile_id_i    ( tile_id_i    ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_ready_o  ( req_ready_o  ),
    .pkt_o        ( pkt_stream   ),
    .pkt_ready_i  ( pkt_ready    )
  );

  ////////////////////
  // NoC output
  ////////////////////

  noc_tx_mux u_tx_mux (
    .clk_i        ( clk_i        ),
    .tile_rst_l_i ( tile_rst_l_o ),
    .irq_i        ( irq_stream   ),
    .pkt_i        ( pkt_stream   ),
    .irq_ready_o  ( irq_ready    ),
    .pkt_ready_o  ( pkt_ready    ),
    .noc_valid_o  ( noc_valid_o  ),
    .noc_data_o   ( noc_data_o   ),
    .noc_ready_i  ( noc_ready_i  )
  );

endmodule

// File: noc_tx_mux.sv
`timescale 1ns/1ps

module noc_tx_mux (
  input  logic                       clk_i,
  input  logic                       tile_rst_l_i,
  input  noc_tile_pkg::flit_stream_t irq_i,
  input  noc_tile_pkg::flit_stream_t pkt_i,
  output logic                       irq_ready_o,
  output logic                       pkt_ready_o,
  output logic                       noc_valid_o,
  output noc_tile_pkg::noc_flit_t    noc_data_o,
  input  logic                       noc_ready_i
);

  logic grant_irq_q;
  logic grant_irq_d;
  logic locked_q;
  logic locked_d;
  logic sel_irq;
  logic sel_last;
  logic fire;

  ////////////////////
  // select
  ////////////////////

  // interrupts first when free, else keep the owner
  assign sel_irq = locked_q ? grant_irq_q : irq_i.valid;

  // straight through, no register stage
  assign noc_valid_o = sel_irq ? irq_i.valid : pkt_i.valid;
  assign noc_data_o  = sel_irq ? irq_i.flit : pkt_i.flit;
  assign sel_last    = sel_irq ? irq_i.last : pkt_i.last;

  // ready only to the owner
  assign irq_ready_o = sel_irq & noc_ready_i;
  assign pkt_ready_o = !sel_irq & noc_ready_i;

  assign fire = noc_valid_o & noc_ready_i;

  ////////////////////
  // packet lock
  ////////////////////

  // hold once a flit is shown so a stalled flit stays put
  // release after the last flit goes
  always_comb begin
    grant_irq_d = grant_irq_q;
    locked_d    = locked_q;
    if (noc_valid_o) begin
      grant_irq_d = sel_irq;
      locked_d    = !(fire && sel_last);
    end
  end

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      grant_irq_q <= 1'b0;
      locked_q    <= 1'b0;
    end else begin
      grant_irq_q <= grant_irq_d;
      locked_q    <= locked_d;
    end
  end

endmodule

// File: req_packetizer.sv
`timescale 1ns/1ps

module req_packetizer #(
  parameter noc_tile_pkg::tile_id_t   DestTile  = '0,
  parameter noc_tile_pkg::noc_fbits_t DestFbits = '0
) (
  input  logic                       clk_i,
  input  logic                       tile_rst_l_i,
  input  noc_tile_pkg::tile_id_t     tile_id_i,
  input  logic                       req_valid_i,
  input  noc_tile_pkg::mem_req_t     req_i,
  output logic                       req_ready_o,
  output noc_tile_pkg::flit_stream_t pkt_o,
  input  logic                       pkt_ready_i
);

  import noc_tile_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HDR,
    ST_ADDR,
    ST_DATA
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  mem_req_t               req_q;
  logic                   ready_q;
  logic                   accept;
  logic                   flit_taken;
  noc_msg_e               msg;
  logic [NocLenWidth-1:0] len;
  noc_flit_t              hdr_flit;

  ////////////////////
  // request side
  ////////////////////

  // registered so it stays low through reset
  assign req_ready_o = ready_q;
  assign accept      = req_valid_i && ready_q;
  assign flit_taken  = pkt_o.valid && pkt_ready_i;

  // one request held at a time
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

  ////////////////////
  // packet FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_HDR;
        end
      end
      ST_HDR: begin
        if (flit_taken) begin
          state_d = ST_ADDR;
        end
      end
      ST_ADDR: begin
        // loads end on the address flit
        if (flit_taken) begin
          state_d = req_q.write ? ST_DATA : ST_IDLE;
        end
      end
      ST_DATA: begin
        if (flit_taken) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge tile_rst_l_i) begin
    if (!tile_rst_l_i) begin
      state_q <= ST_IDLE;
      ready_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // free again once the last flit leaves
      ready_q <= (state_d == ST_IDLE);
    end
  end

  ////////////////////
  // flit out
  ////////////////////

  // store carries address and data, load only address
  assign msg      = req_q.write ? MSG_STORE : MSG_LOAD;
  assign len      = req_q.write ? 8'd2 : 8'd1;
  assign hdr_flit = noc_make_hdr(DestTile, DestFbits, len, msg, tile_id_i);

  always_comb begin
    pkt_o       = '0;
    pkt_o.valid = (state_q != ST_IDLE);
    case (state_q)
      ST_ADDR: begin
        pkt_o.flit = req_q.addr;
        pkt_o.last = !req_q.write;
      end
      ST_DATA: begin
        pkt_o.flit = req_q.data;
        pkt_o.last = 1'b1;
      end
      default: begin
        pkt_o.flit = hdr_flit;
      end
    endcase
  end

endmodule

// File: src.f
noc_tile_pkg.sv
tile_reset_ctrl.sv
irq_notifier.sv
req_packetizer.sv
noc_tx_mux.sv
noc_tile_top.sv
tb_clk_gen.sv
tb_noc_tile.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_l_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for two rising edges, released on an edge
  initial begin
    rst_l_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_l_o <= 1'b1;
  end

endmodule

// File: tb_noc_tile.sv
`timescale 1ns/1ps

module tb_noc_tile;

  import noc_tile_pkg::*;

  ////////////////////
  // setup
  ////////////////////

  localparam int unsigned WakeCntWidth  = 5;
  localparam int unsigned NumReqs       = 200;
  localparam int unsigned TimeoutCycles = NumReqs * 3 * 8 + 100;
  // tile reset release window after reset_l rises
  localparam int unsigned WakeMin = 2 ** (WakeCntWidth - 1);
  localparam int unsigned WakeMax = WakeMin + 3;

  localparam tile_id_t   DestTile  = '{chipid: 14'h012, x: 8'h03, y: 8'h05};
  localparam noc_fbits_t DestFbits = 4'ha;
  localparam tile_id_t   TileId    = '{chipid: 14'h001, x: 8'h3b, y: 8'h07};

  logic       clk;
  logic       reset_l;
  tile_id_t   tile_id_i;
  logic       req_valid_i;
  mem_req_t   req_i;
  logic       req_ready_o;
  irq_lines_t irq_lines_i;
  logic       noc_valid_o;
  noc_flit_t  noc_data_o;
  logic       noc_ready_i;
  logic       tile_rst_l_o;

  // random source and stimulus state
  logic [31:0] lcg_state;
  logic [31:0] stim_rnd;
  int unsigned req_issued;
  int unsigned irq_hold;
  logic [4:0]  irq_next;
  logic [4:0]  irq_final;
  logic        freeze_irq;
  logic        irq_frozen;
  bit          irq_seen [0:31];

  // model and monitor state
  mem_req_t    req_model [$];
  mem_req_t    cur_req;
  logic        req_taken;
  int unsigned accepted;
  int unsigned reqs_checked;
  int unsigned irq_pkts;
  int unsigned flit_cnt;
  int unsigned pkt_pos;
  int unsigned pkt_len;
  logic        pkt_irq;
  logic [4:0]  last_irq;
  logic        stall_pend;
  noc_flit_t   stall_data;
  logic        rst_seen;
  int unsigned wake_cycles;
  int unsigned err_cnt;
  int unsigned cycle_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk     ),
    .rst_l_o ( reset_l )
  );

  noc_tile_top #(
    .WakeCntWidth ( WakeCntWidth ),
    .DestTile     ( DestTile     ),
    .DestFbits    ( DestFbits    )
  ) u_dut (
    .clk_i        ( clk          ),
    .reset_l      ( reset_l      ),
    .tile_id_i    ( tile_id_i    ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_ready_o  ( req_ready_o  ),
    .irq_lines_i  ( irq_lines_i  ),
    .noc_valid_o  ( noc_valid_o  ),
    .noc_data_o   ( noc_data_o   ),
    .noc_ready_i  ( noc_ready_i  ),
    .tile_rst_l_o ( tile_rst_l_o )
  );

  ////////////////////
  // helpers
  ////////////////////

  // numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    err_cnt = err_cnt + 1;
    $display("error at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
  endtask

  task automatic report_failure(input string msg);
    err_cnt = err_cnt + 1;
    $display("failure at %0t: %s", $time, msg);
  endtask

  task automatic print_summary();
    $display("summary: errors=%0d requests=%0d irq_packets=%0d flits=%0d cycles=%0d",
             err_cnt, reqs_checked, irq_pkts, flit_cnt, cycle_cnt);
  endtask

  // splits the NoC stream into packets by header type
  task automatic collect_flit(input noc_flit_t flit, input logic last);
    noc_hdr_t hdr;
    noc_msg_e exp_msg;
    logic     exp_last;
    hdr      = noc_hdr_t'(flit);
    flit_cnt = flit_cnt + 1;
    if (pkt_pos == 0) begin
      if (hdr.rsvd != '0) report_mismatch("hdr.rsvd", '0, hdr.rsvd);
      if (hdr.dest != DestTile) report_mismatch("hdr.dest", DestTile, hdr.dest);
      if (hdr.dest_fbits != DestFbits) report_mismatch("hdr.dest_fbits", DestFbits, hdr.dest_fbits);
      if (hdr.src_x != TileId.x[3:0]) report_mismatch("hdr.src_x", TileId.x[3:0], hdr.src_x);
      case (hdr.msg)
        MSG_INTR: begin
          pkt_irq = 1'b1;
          pkt_len = 1;
        end
        MSG_LOAD, MSG_STORE: begin
          pkt_irq = 1'b0;
          if (req_model.size() == 0) begin
            report_failure("request packet seen with no accepted request left");
            cur_req = '0;
          end else begin
            cur_req = req_model.pop_front();
          end
          exp_msg = cur_req.write ? MSG_STORE : MSG_LOAD;
          pkt_len = cur_req.write ? 2 : 1;
          if (hdr.msg != exp_msg) report_mismatch("hdr.msg", exp_msg, hdr.msg);
        end
        default: begin
          report_failure("header carries an unknown message type");
          pkt_irq = 1'b0;
          pkt_len = hdr.len;
        end
      endcase
      if (hdr.len != pkt_len) report_mismatch("hdr.len", pkt_len, hdr.len);
    end else if (pkt_irq) begin
      // payload is the 5 line bits, rest zero
      if (flit[63:5] != '0) report_mismatch("irq payload upper bits", '0, flit[63:5]);
      if (!irq_seen[flit[4:0]]) begin
        report_failure($sformatf("irq payload %h was never driven", flit[4:0]));
      end
      last_irq = flit[4:0];
      irq_pkts = irq_pkts + 1;
    end else if (pkt_pos == 1) begin
      if (flit != cur_req.addr) report_mismatch("noc_data_o addr", cur_req.addr, flit);
    end else begin
      if (flit != cur_req.data) report_mismatch("noc_data_o data", cur_req.data, flit);
    end
    exp_last = (pkt_pos == pkt_len);
    if (last !== exp_last) report_mismatch("sel_last", exp_last, last);
    if (exp_last) begin
      if (!pkt_irq && pkt_pos != 0) reqs_checked = reqs_checked + 1;
      pkt_pos = 0;
    end else begin
      pkt_pos = pkt_pos + 1;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  always @(posedge clk) begin
    if (reset_l) begin
      stim_rnd = lcg_next();
      // roughly half the cycles the NoC takes a flit
      noc_ready_i <= stim_rnd[31];
      // request held until taken, then a new one or a gap
      if (!req_valid_i || req_taken) begin
        if (req_issued < NumReqs && stim_rnd[30:29] != 2'b00) begin
          req_valid_i <= 1'b1;
          req_i.write <= stim_rnd[28];
          req_i.addr  <= {lcg_next(), lcg_next()};
          req_i.data  <= {lcg_next(), lcg_next()};
          req_issued  <= req_issued + 1;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      // interrupt lines change rarely and hold at least 6 cycles
      if (irq_hold != 0) begin
        irq_hold <= irq_hold - 1;
      end else if (freeze_irq) begin
        if (!irq_frozen) begin
          irq_final = irq_lines_i ^ 5'h1f;
          irq_seen[irq_final] = 1'b1;
          irq_lines_i <= irq_lines_t'(irq_final);
          irq_frozen  <= 1'b1;
        end
      end else if (stim_rnd[27:24] == 4'h0) begin
        irq_next = stim_rnd[20:16];
        irq_seen[irq_next] = 1'b1;
        irq_lines_i <= irq_lines_t'(irq_next);
        irq_hold    <= 6 + stim_rnd[23:21];
      end
    end
  end

  ////////////////////
  // monitor
  ////////////////////

  // sampled mid-cycle, transfers happen on the next rising edge
  always @(negedge clk) begin
    if (reset_l && !rst_seen) begin
      if (tile_rst_l_o) begin
        rst_seen = 1'b1;
        if (wake_cycles < WakeMin || wake_cycles > WakeMax) begin
          report_failure($sformatf("tile_rst_l_o rose after %0d cycles, not %0d to %0d",
                                   wake_cycles, WakeMin, WakeMax));
        end
      end else begin
        wake_cycles = wake_cycles + 1;
        if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", 1'b0, req_ready_o);
        if (noc_valid_o !== 1'b0) report_mismatch("noc_valid_o", 1'b0, noc_valid_o);
      end
    end
    req_taken = req_valid_i && req_ready_o;
    if (req_taken) begin
      req_model.push_back(req_i);
      accepted = accepted + 1;
    end
    // offered flit must not move while stalled
    if (stall_pend) begin
      if (noc_valid_o !== 1'b1) begin
        report_failure("noc_valid_o dropped before the flit was taken");
      end else if (noc_data_o !== stall_data) begin
        report_mismatch("noc_data_o", stall_data, noc_data_o);
      end
    end
    stall_pend = noc_valid_o && !noc_ready_i;
    stall_data = noc_data_o;
    if (noc_valid_o && noc_ready_i) begin
      collect_flit(noc_data_o, u_dut.u_tx_mux.sel_last);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      report_failure("timeout, the run did not complete");
      print_summary();
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////
  // main
  ////////////////////

  initial begin
    tile_id_i    = TileId;
    req_valid_i  = 1'b0;
    req_i        = '0;
    irq_lines_i  = '0;
    noc_ready_i  = 1'b0;
    lcg_state    = 32'hc4daaa7b;
    req_issued   = 0;
    irq_hold     = 0;
    irq_final    = '0;
    freeze_irq   = 1'b0;
    irq_frozen   = 1'b0;
    req_taken    = 1'b0;
    accepted     = 0;
    reqs_checked = 0;
    irq_pkts     = 0;
    flit_cnt     = 0;
    pkt_pos      = 0;
    pkt_len      = 0;
    pkt_irq      = 1'b0;
    last_irq     = '0;
    stall_pend   = 1'b0;
    stall_data   = '0;
    rst_seen     = 1'b0;
    wake_cycles  = 0;
    err_cnt      = 0;
    cycle_cnt    = 0;
    for (int i = 0; i < 32; i++) begin
      irq_seen[i] = 1'b0;
    end
    // reset value counts as reported
    irq_seen[0] = 1'b1;

    // all requests through and their packets closed
    @(posedge clk);
    while (!(accepted == NumReqs && req_model.size() == 0 && pkt_pos == 0)) begin
      @(posedge clk);
    end
    freeze_irq <= 1'b1;
    while (!(irq_frozen && pkt_pos == 0 && last_irq == irq_final)) begin
      @(posedge clk);
    end
    // let any late interrupt packet drain
    repeat (40) @(posedge clk);

    if (last_irq != irq_final) report_mismatch("last irq payload", irq_final, last_irq);
    if (reqs_checked != NumReqs) report_mismatch("requests checked", NumReqs, reqs_checked);
    if (pkt_pos != 0) report_failure("run ended inside a packet");
    if (!rst_seen) report_failure("tile reset never released");

    print_summary();
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tile_reset_ctrl.sv
`timescale 1ns/1ps

module tile_reset_ctrl #(
  parameter int unsigned WakeCntWidth = 16
) (
  input  logic clk_i,
  input  logic reset_l,
  output logic tile_rst_l_o
);

  logic [WakeCntWidth-1:0] wake_cnt_q;
  logic [WakeCntWidth-1:0] wake_cnt_d;
  logic                    wake_done;
  logic                    rst_gated;
  logic [1:0]              rst_sync_q;

  ////////////////////
  // wake-up count
  ////////////////////

  // give the memories time to come up before the tile runs
  assign wake_done = wake_cnt_q[WakeCntWidth-1];
  // saturate once the top bit is set
  assign wake_cnt_d = wake_done ? wake_cnt_q : wake_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else begin
      wake_cnt_q <= wake_cnt_d;
    end
  end

  // external reset still wins while counting
  assign rst_gated = wake_done & reset_l;

  ////////////////////
  // reset sync
  ////////////////////

  // asserts at once, releases two edges later
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[0], rst_gated};
    end
  end

  assign tile_rst_l_o = rst_sync_q[1];

endmodule
